//--- testbench/lsu_stim.txt
// columns: size write unsigned addr wdata expected
// size 1 byte, 2 half, 3 word, 0 idle, f ends the file; expected is 0 for stores
// word store then word load
3 1 0 00000010 deadbeef 00000000
3 0 0 00000010 00000000 deadbeef
// one byte lane written over a known word, the other lanes keep their value
3 1 0 00000020 11223344 00000000
1 1 0 00000021 ffffffaa 00000000
3 0 0 00000020 00000000 1122aa44
// bytes into all four lanes, upper store data bits must be dropped
1 1 0 00000020 12345681 00000000
1 1 0 00000021 00000082 00000000
1 1 0 00000022 00000083 00000000
1 1 0 00000023 00000084 00000000
3 0 0 00000020 00000000 84838281
// halfwords into the low and high pair
2 1 0 00000030 abcd1234 00000000
2 1 0 00000032 0000beef 00000000
3 0 0 00000030 00000000 beef1234
// signed and unsigned byte and halfword loads
1 0 0 00000021 00000000 ffffff82
1 0 1 00000021 00000000 00000082
2 0 0 00000032 00000000 ffffbeef
2 0 1 00000032 00000000 0000beef
2 0 0 00000030 00000000 00001234
1 0 0 00000013 00000000 ffffffde
// idle op, no pulse expected
0 0 0 00000010 00000000 00000000
f 0 0 00000000 00000000 00000000

//--- all.f
source/lsu_pkg.sv
source/lsu_request.sv
source/load_align.sv
source/data_ram.sv
source/lsu_top.sv
testbench/lsu_tb.sv

//--- Makefile
# Verilator build and run of the load/store testbench.
TOP := lsu_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

# the log decides the result, a fail line or a missing pass line fails the target.
sim:
	verilator --binary --timing -f all.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ) sim.log

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

	import lsu_pkg::*;

	// the clock runs at 25 MHz, so half a period is 20 ns.
	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 4;
	// each line of the data file holds six fields, and the file ends with a size code of f.
	localparam int STIM_COLS    = 6;
	localparam int STIM_MAX     = 64;
	localparam int END_CODE     = 15;
	// completion delays counted from the edge that samples the op.
	localparam int STORE_LAT    = 2;
	localparam int LOAD_LAT     = 3;
	localparam int WAIT_LIMIT   = 8;
	localparam int IDLE_WINDOW  = 6;
	// the watchdog allows this many cycles for each line of the file.
	localparam int TEST_CYCLES  = 10;

	logic      clk;
	logic      rst_n;
	lsu_op_t   op;
	lsu_word_t load_data;
	logic      load_valid;
	logic      store_done;

	logic [31:0] stim_mem [0:STIM_COLS*STIM_MAX-1];
	logic        stim_ready = 1'b0;
	int          n_tests;
	int          n_pass;
	int          n_fail;
	int          check_errors;

	lsu_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_i         (op),
		.load_data_o  (load_data),
		.load_valid_o (load_valid),
		.store_done_o (store_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// builds the core operation of one line of the data file.
	function automatic lsu_op_t op_from_line(input int idx);
		lsu_op_t o;
		int      base;
		base            = idx * STIM_COLS;
		o.size          = lsu_size_e'(stim_mem[base][1:0]);
		o.write         = stim_mem[base+1][0];
		o.unsigned_load = stim_mem[base+2][0];
		o.addr          = stim_mem[base+3];
		o.wdata         = stim_mem[base+4];
		return o;
	endfunction

	// a short name of the operation for the per-test line.
	function automatic string op_name(input lsu_op_t o);
		string sz;
		case (o.size)
			SIZE_BYTE: sz = "byte";
			SIZE_HALF: sz = "half";
			SIZE_WORD: sz = "word";
			default:   sz = "idle";
		endcase
		if (o.size == SIZE_NONE)
		begin
			return sz;
		end
		return $sformatf("%s %s at %h", sz, o.write ? "store" : "load", o.addr);
	endfunction

	// compares a load result with the value that the data file expects.
	task automatic check_load(input lsu_word_t got, input lsu_word_t exp, input int idx);
		if (got !== exp)
		begin
			$display("ERROR at %0d ns: test %0d load returned %h, expected %h",
				$time, idx, got, exp);
			check_errors++;
		end
	endtask

	// compares the counted completion delay with the fixed bus timing.
	task automatic check_latency(input int got, input int want, input int idx);
		if (got != want)
		begin
			$display("ERROR at %0d ns: test %0d completed after %0d cycles, expected %0d",
				$time, idx, got, want);
			check_errors++;
		end
	endtask

	// presents the op for exactly one cycle and then returns to idle.
	// the op is sampled by the DUT on the second of these two edges.
	task automatic drive_op(input lsu_op_t o);
		@(posedge clk);
		op <= o;
		@(posedge clk);
		op <= '0;
	endtask

	// counts edges after the op edge until the expected pulse shows up.
	// outputs are looked at on the falling edge, where they are settled.
	task automatic wait_done(input logic is_load, output int cycles, output logic seen,
		output logic stray);
		cycles = 0;
		seen   = 1'b0;
		stray  = 1'b0;
		@(negedge clk);
		while (!seen && cycles < WAIT_LIMIT)
		begin
			if (is_load ? load_valid : store_done)
			begin
				seen = 1'b1;
			end
			else
			begin
				// the other completion pulse must stay quiet during this op.
				if (is_load ? store_done : load_valid)
				begin
					stray = 1'b1;
				end
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// an idle op must not start a bus transfer, so neither pulse may appear.
	task automatic watch_idle(output logic stray);
		stray = 1'b0;
		repeat (IDLE_WINDOW)
		begin
			@(negedge clk);
			if (load_valid || store_done)
			begin
				stray = 1'b1;
			end
		end
	endtask

	// runs one line of the data file and reports it.
	task automatic run_test(input int idx);
		lsu_op_t   op_line;
		lsu_word_t expected;
		int        cycles;
		int        errors_before;
		logic      seen;
		logic      stray;
		op_line       = op_from_line(idx);
		expected      = stim_mem[idx*STIM_COLS+5];
		errors_before = check_errors;
		drive_op(op_line);
		if (op_line.size == SIZE_NONE)
		begin
			watch_idle(stray);
			if (stray)
			begin
				$display("test %0d: an idle op produced a completion pulse", idx);
				check_errors++;
			end
		end
		else
		begin
			wait_done(!op_line.write, cycles, seen, stray);
			if (!seen)
			begin
				$display("test %0d: no completion pulse within %0d cycles", idx, WAIT_LIMIT);
				check_errors++;
			end
			else
			begin
				if (stray)
				begin
					$display("test %0d: the wrong completion pulse fired", idx);
					check_errors++;
				end
				check_latency(cycles, op_line.write ? STORE_LAT : LOAD_LAT, idx);
				if (!op_line.write)
				begin
					check_load(load_data, expected, idx);
				end
			end
		end
		if (check_errors == errors_before)
		begin
			n_pass++;
			$display("test %0d: %s passed", idx, op_name(op_line));
		end
		else
		begin
			n_fail++;
			$display("test %0d: %s failed", idx, op_name(op_line));
		end
	endtask

	initial
	begin
		op           = '0;
		rst_n        = 1'b0;
		n_tests      = 0;
		n_pass       = 0;
		n_fail       = 0;
		check_errors = 0;
		$readmemh("testbench/lsu_stim.txt", stim_mem);
		while (n_tests < STIM_MAX && stim_mem[n_tests*STIM_COLS] !== END_CODE)
		begin
			n_tests++;
		end
		stim_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < n_tests; i++)
		begin
			run_test(i);
		end
		@(posedge clk);
		$display("summary: %0d tests, %0d passed, %0d failed", n_tests, n_pass, n_fail);
		if (n_fail == 0 && n_tests > 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// ends a run that hangs, with a budget that grows with the number of lines.
	initial
	begin
		wait (stim_ready);
		repeat (RESET_CYCLES + n_tests * TEST_CYCLES) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles",
			RESET_CYCLES + n_tests * TEST_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
	input  logic               clk,
	input  logic               rst_n,
	input  lsu_pkg::lsu_op_t   op_i,
	output lsu_pkg::lsu_word_t load_data_o,
	output logic               load_valid_o,
	output logic               store_done_o
);

	import lsu_pkg::*;

	// the request goes to the RAM and to the aligner.
	// the response comes back to the request unit and the aligner.
	lsu_bus_req_t bus_req;
	lsu_bus_rsp_t bus_rsp;

	// turns a core operation into a held bus request.
	lsu_request u_request (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_i         (op_i),
		.bus_rsp_i    (bus_rsp),
		.bus_req_o    (bus_req),
		.store_done_o (store_done_o)
	);

	// answers the bus with a grant and, for reads, the addressed word.
	data_ram u_ram (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_req_i (bus_req),
		.bus_rsp_o (bus_rsp)
	);

	// cuts the loaded byte or halfword out of the word and extends it.
	load_align u_align (
		.clk          (clk),
		.rst_n        (rst_n),
		.bus_req_i    (bus_req),
		.bus_rsp_i    (bus_rsp),
		.load_data_o  (load_data_o),
		.load_valid_o (load_valid_o)
	);

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps

module data_ram (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lsu_pkg::lsu_bus_req_t bus_req_i,
	output lsu_pkg::lsu_bus_rsp_t bus_rsp_o
);

	import lsu_pkg::*;

	lsu_word_t         mem [RAM_WORDS];
	logic [RAM_AW-1:0] idx;
	logic              accept;
	logic              gnt_q;
	logic              rvalid_q;
	lsu_word_t         rdata_q;

	// only the low bits of the word address reach the array.
	// word addresses that differ only in higher bits alias.
	assign idx = bus_req_i.addr[RAM_AW-1:0];

	// req stays high through the grant cycle, so a live grant blocks a second accept.
	assign accept = bus_req_i.req && !gnt_q;

	// grant and read-valid are single-cycle pulses.
	// rvalid follows the grant of a read by one cycle.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			gnt_q    <= 1'b0;
			rvalid_q <= 1'b0;
		end
		else
		begin
			gnt_q    <= accept;
			rvalid_q <= gnt_q && bus_req_i.req && !bus_req_i.we;
		end
	end

	// a write commits on the edge that raises the grant.
	// only the enabled byte lanes of the word change.
	always_ff @(posedge clk)
	begin
		if (accept && bus_req_i.we)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (bus_req_i.be[b])
				begin
					mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
				end
			end
		end
	end

	// a read takes the whole word in the grant cycle.
	// the aligner picks the lane one cycle later.
	always_ff @(posedge clk)
	begin
		if (gnt_q && bus_req_i.req && !bus_req_i.we)
		begin
			rdata_q <= mem[idx];
		end
	end

	assign bus_rsp_o.gnt    = gnt_q;
	assign bus_rsp_o.rvalid = rvalid_q;
	assign bus_rsp_o.rdata  = rdata_q;

endmodule

//--- source/load_align.sv
`timescale 1ns/1ps

module load_align (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lsu_pkg::lsu_bus_req_t bus_req_i,
	input  lsu_pkg::lsu_bus_rsp_t bus_rsp_i,
	output lsu_pkg::lsu_word_t    load_data_o,
	output logic                  load_valid_o
);

	import lsu_pkg::*;

	logic      read_grant;
	logic      uns_q;
	logic      valid_q;
	lsu_be_t   be_q;
	lsu_word_t aligned;
	lsu_word_t data_q;

	// extends one byte to a word, with zeros or with copies of its top bit.
	function automatic lsu_word_t ext_byte(input logic [7:0] b, input logic uns);
		ext_byte = {{24{b[7] & ~uns}}, b};
	endfunction

	// extends one halfword to a word in the same way.
	function automatic lsu_word_t ext_half(input logic [15:0] h, input logic uns);
		ext_half = {{16{h[15] & ~uns}}, h};
	endfunction

	// the request fields are still stable in the grant cycle, so the lane is taken there.
	assign read_grant = bus_req_i.req && !bus_req_i.we && bus_rsp_i.gnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			be_q    <= '0;
			uns_q   <= 1'b0;
			valid_q <= 1'b0;
		end
		else
		begin
			if (read_grant)
			begin
				be_q  <= bus_req_i.be;
				uns_q <= bus_req_i.unsigned_load;
			end
			valid_q <= bus_rsp_i.rvalid;
		end
	end

	// the latched enables say which lane holds the load; a full word passes as it is.
	always_comb
	begin
		case (be_q)
			4'b0001: aligned = ext_byte(bus_rsp_i.rdata[7:0], uns_q);
			4'b0010: aligned = ext_byte(bus_rsp_i.rdata[15:8], uns_q);
			4'b0100: aligned = ext_byte(bus_rsp_i.rdata[23:16], uns_q);
			4'b1000: aligned = ext_byte(bus_rsp_i.rdata[31:24], uns_q);
			4'b0011: aligned = ext_half(bus_rsp_i.rdata[15:0], uns_q);
			4'b1100: aligned = ext_half(bus_rsp_i.rdata[31:16], uns_q);
			default: aligned = bus_rsp_i.rdata;
		endcase
	end

	// the result is held until the next read completes.
	always_ff @(posedge clk)
	begin
		if (bus_rsp_i.rvalid)
		begin
			data_q <= aligned;
		end
	end

	assign load_data_o  = data_q;
	assign load_valid_o = valid_q;

endmodule

//--- source/lsu_request.sv
`timescale 1ns/1ps

module lsu_request (
	input  logic                 clk,
	input  logic                 rst_n,
	input  lsu_pkg::lsu_op_t     op_i,
	input  lsu_pkg::lsu_bus_rsp_t bus_rsp_i,
	output lsu_pkg::lsu_bus_req_t bus_req_o,
	output logic                 store_done_o
);

	import lsu_pkg::*;

	// the unit is either free to take an operation or waiting for the grant.
	typedef enum logic {
		REQ_IDLE,
		REQ_WAIT
	} req_state_e;

	req_state_e state_q;
	logic       issue;
	logic       we_q;
	logic       uns_q;
	logic       store_done_q;
	lsu_be_t    be_q;
	lsu_be_t    lane_be;
	lsu_addr_t  addr_q;
	lsu_word_t  wdata_q;
	lsu_word_t  lane_wdata;

	// a new operation is only taken while no request is outstanding.
	assign issue = (state_q == REQ_IDLE) && (op_i.size != SIZE_NONE);

	// byte enables and lane placement of the store data, taken from the size code.
	// bytes use addr[1:0], halfwords use addr[1] only, and bit 0 is ignored for them.
	always_comb
	begin
		lane_be    = '0;
		lane_wdata = '0;
		case (op_i.size)
			SIZE_BYTE:
			begin
				case (op_i.addr[1:0])
					2'b00:
					begin
						lane_be          = 4'b0001;
						lane_wdata[7:0]  = op_i.wdata[7:0];
					end
					2'b01:
					begin
						lane_be          = 4'b0010;
						lane_wdata[15:8] = op_i.wdata[7:0];
					end
					2'b10:
					begin
						lane_be           = 4'b0100;
						lane_wdata[23:16] = op_i.wdata[7:0];
					end
					default:
					begin
						lane_be           = 4'b1000;
						lane_wdata[31:24] = op_i.wdata[7:0];
					end
				endcase
			end
			SIZE_HALF:
			begin
				if (op_i.addr[1])
				begin
					lane_be           = 4'b1100;
					lane_wdata[31:16] = op_i.wdata[15:0];
				end
				else
				begin
					lane_be          = 4'b0011;
					lane_wdata[15:0] = op_i.wdata[15:0];
				end
			end
			SIZE_WORD:
			begin
				lane_be    = '1;
				lane_wdata = op_i.wdata;
			end
			default:
			begin
				lane_be    = '0;
				lane_wdata = '0;
			end
		endcase
	end

	// control state of the request.
	// we and be are cleared at the grant so the bus is quiet between operations.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q      <= REQ_IDLE;
			we_q         <= 1'b0;
			be_q         <= '0;
			store_done_q <= 1'b0;
		end
		else
		begin
			// a write is done on the edge that sees its grant.
			store_done_q <= (state_q == REQ_WAIT) && bus_rsp_i.gnt && we_q;
			case (state_q)
				REQ_IDLE:
				begin
					if (issue)
					begin
						state_q <= REQ_WAIT;
						we_q    <= op_i.write;
						be_q    <= lane_be;
					end
				end
				default:
				begin
					if (bus_rsp_i.gnt)
					begin
						state_q <= REQ_IDLE;
						we_q    <= 1'b0;
						be_q    <= '0;
					end
				end
			endcase
		end
	end

	// payload of the request, loaded once per operation and held until the grant.
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			addr_q  <= {2'b00, op_i.addr[31:2]};
			wdata_q <= lane_wdata;
			uns_q   <= op_i.unsigned_load;
		end
	end

	assign bus_req_o.req           = (state_q == REQ_WAIT);
	assign bus_req_o.we            = we_q;
	assign bus_req_o.unsigned_load = uns_q;
	assign bus_req_o.be            = be_q;
	assign bus_req_o.addr          = addr_q;
	assign bus_req_o.wdata         = wdata_q;
	assign store_done_o            = store_done_q;

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

	// data path and address widths of the core side and the data bus.
	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;
	localparam int BE_W   = WORD_W / 8;

	// the data RAM holds 256 words, so the low 8 bits of the word address select one.
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

	typedef logic [WORD_W-1:0] lsu_word_t;
	typedef logic [ADDR_W-1:0] lsu_addr_t;
	typedef logic [BE_W-1:0]   lsu_be_t;

	// size code of a memory operation; SIZE_NONE marks an idle cycle.
	typedef enum logic [1:0] {
		SIZE_NONE = 2'b00,
		SIZE_BYTE = 2'b01,
		SIZE_HALF = 2'b10,
		SIZE_WORD = 2'b11
	} lsu_size_e;

	// one operation as the core presents it, with a byte address and unaligned store data.
	typedef struct packed {
		lsu_size_e size;
		logic      write;
		logic      unsigned_load;
		lsu_addr_t addr;
		lsu_word_t wdata;
	} lsu_op_t;

	// data bus request; addr is a word address and wdata sits in its byte lane.
	// unsigned_load rides along for the load aligner and the RAM does not look at it.
	typedef struct packed {
		logic      req;
		logic      we;
		logic      unsigned_load;
		lsu_be_t   be;
		lsu_addr_t addr;
		lsu_word_t wdata;
	} lsu_bus_req_t;

	// data bus response with the grant pulse and the read-valid strobe.
	typedef struct packed {
		logic      gnt;
		logic      rvalid;
		lsu_word_t rdata;
	} lsu_bus_rsp_t;

endpackage
